//--- Bender.yml
package:
  name: la32_pipeline

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/cpu_pkg.sv
      - hw/decoder.sv
      - hw/regfile.sv
      - hw/alu.sv
      - hw/forward_unit.sv
      - hw/cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clock.sv
      - tests/tb_cpu.sv

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLT:  result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: result = word_t'(a < b);
            ALU_AND:  result = a & b;
            ALU_NOR:  result = ~(a | b);
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            // upper immediate already shifted by the decoder
            ALU_LUI:  result = b;
            default:  result = '0;
        endcase
    end

    // x only before the first clock edge of reset
    known_op: assert final ($isunknown(op) || op inside {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    });

endmodule

//--- hw/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    // ALU operations, shared by the immediate and register forms
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    // branch condition, resolved in execute
    typedef enum logic [2:0] {
        BR_NONE   = 3'd0,
        BR_EQ     = 3'd1,
        BR_NE     = 3'd2,
        BR_LT     = 3'd3,
        BR_GE     = 3'd4,
        BR_LTU    = 3'd5,
        BR_GEU    = 3'd6,
        BR_ALWAYS = 3'd7
    } br_kind_e;

endpackage

//--- hw/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top (
    input  logic               clk,
    input  logic               reset,
    output cpu_pkg::word_t     imem_addr,
    input  cpu_pkg::word_t     imem_rdata,
    output logic               dmem_we,
    output cpu_pkg::word_t     dmem_addr,
    output cpu_pkg::word_t     dmem_wdata,
    input  cpu_pkg::word_t     dmem_rdata,
    output logic               wb_valid,
    output cpu_pkg::word_t     wb_pc,
    output cpu_pkg::reg_addr_t wb_reg,
    output cpu_pkg::word_t     wb_data
);
    import cpu_pkg::*;

    word_t     pc;
    word_t     next_pc;
    logic      br_cond;
    logic      br_taken;
    logic      stall;

    logic      fd_valid;
    word_t     fd_pc;
    word_t     fd_inst;

    alu_op_e   id_alu_op;
    br_kind_e  id_br_kind;
    logic      id_src1_is_pc;
    logic      id_src2_is_imm;
    logic      id_rs2_is_rd;
    logic      id_reg_we;
    logic      id_mem_we;
    logic      id_mem_read;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2_field;
    reg_addr_t id_rs2;
    reg_addr_t id_dest;
    word_t     id_imm;
    word_t     id_br_target;
    word_t     id_rdata1;
    word_t     id_rdata2;

    logic      de_valid;
    word_t     de_pc;
    alu_op_e   de_alu_op;
    br_kind_e  de_br_kind;
    logic      de_src1_is_pc;
    logic      de_src2_is_imm;
    logic      de_reg_we;
    logic      de_mem_we;
    logic      de_mem_read;
    reg_addr_t de_rs1;
    reg_addr_t de_rs2;
    reg_addr_t de_dest;
    word_t     de_imm;
    word_t     de_br_target;
    word_t     de_rdata1;
    word_t     de_rdata2;
    word_t     ex_op1;
    word_t     ex_op2;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;

    logic      em_valid;
    logic      em_reg_we;
    logic      em_mem_we;
    logic      em_mem_read;
    word_t     em_pc;
    reg_addr_t em_dest;
    word_t     em_result;
    word_t     em_wdata;
    word_t     mem_result;

    logic      mw_valid;
    logic      mw_reg_we;
    word_t     mw_pc;
    reg_addr_t mw_dest;
    word_t     mw_data;

    // fetch
    always_comb begin
        if (br_taken) begin
            next_pc = de_br_target;
        end else if (stall) begin
            next_pc = pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    assign imem_addr = next_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC - 32'd4;
        end else begin
            pc <= next_pc;
        end
    end

    // valid bits, the redirected fetch already holds the branch target
    always_ff @(posedge clk) begin
        if (reset) begin
            fd_valid <= 1'b0;
            de_valid <= 1'b0;
            em_valid <= 1'b0;
            mw_valid <= 1'b0;
        end else begin
            if (!stall) begin
                fd_valid <= 1'b1;
            end
            de_valid <= fd_valid && !br_taken && !stall;
            em_valid <= de_valid;
            mw_valid <= em_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fd_pc   <= next_pc;
            fd_inst <= imem_rdata;
        end
    end

    // decode
    decoder u_decoder (
        .inst        (fd_inst),
        .pc          (fd_pc),
        .alu_op      (id_alu_op),
        .br_kind     (id_br_kind),
        .src1_is_pc  (id_src1_is_pc),
        .src2_is_imm (id_src2_is_imm),
        .rs2_is_rd   (id_rs2_is_rd),
        .reg_we      (id_reg_we),
        .mem_we      (id_mem_we),
        .mem_read    (id_mem_read),
        .rs1         (id_rs1),
        .rs2         (id_rs2_field),
        .dest        (id_dest),
        .imm         (id_imm),
        .br_target   (id_br_target)
    );

    // stores and branches read rd on the second port
    assign id_rs2 = id_rs2_is_rd ? id_dest : id_rs2_field;

    regfile u_regfile (
        .clk    (clk),
        .we     (mw_valid && mw_reg_we),
        .waddr  (mw_dest),
        .wdata  (mw_data),
        .raddr1 (id_rs1),
        .raddr2 (id_rs2),
        .rdata1 (id_rdata1),
        .rdata2 (id_rdata2)
    );

    always_ff @(posedge clk) begin
        de_pc          <= fd_pc;
        de_alu_op      <= id_alu_op;
        de_br_kind     <= id_br_kind;
        de_src1_is_pc  <= id_src1_is_pc;
        de_src2_is_imm <= id_src2_is_imm;
        de_reg_we      <= id_reg_we;
        de_mem_we      <= id_mem_we;
        de_mem_read    <= id_mem_read;
        de_rs1         <= id_rs1;
        de_rs2         <= id_rs2;
        de_dest        <= id_dest;
        de_imm         <= id_imm;
        de_br_target   <= id_br_target;
        de_rdata1      <= id_rdata1;
        de_rdata2      <= id_rdata2;
    end

    // execute
    forward_unit u_forward_unit (
        .clk        (clk),
        .reset      (reset),
        .ex_rs1     (de_rs1),
        .ex_rs2     (de_rs2),
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .mem_dest   (em_dest),
        .wb_dest    (mw_dest),
        .ex_dest    (de_dest),
        .mem_we     (em_valid && em_reg_we),
        .wb_we      (mw_valid && mw_reg_we),
        .ex_is_load (de_valid && de_mem_read),
        .mem_value  (em_result),
        .wb_value   (mw_data),
        .rf1        (de_rdata1),
        .rf2        (de_rdata2),
        .op1        (ex_op1),
        .op2        (ex_op2),
        .stall      (stall)
    );

    always_comb begin
        case (de_br_kind)
            BR_EQ:     br_cond = ex_op1 == ex_op2;
            BR_NE:     br_cond = ex_op1 != ex_op2;
            BR_LT:     br_cond = $signed(ex_op1) < $signed(ex_op2);
            BR_GE:     br_cond = $signed(ex_op1) >= $signed(ex_op2);
            BR_LTU:    br_cond = ex_op1 < ex_op2;
            BR_GEU:    br_cond = ex_op1 >= ex_op2;
            BR_ALWAYS: br_cond = 1'b1;
            default:   br_cond = 1'b0;
        endcase
    end

    assign br_taken = de_valid && br_cond;
    assign alu_a    = de_src1_is_pc ? de_pc : ex_op1;
    assign alu_b    = de_src2_is_imm ? de_imm : ex_op2;

    alu u_alu (
        .op     (de_alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        em_pc       <= de_pc;
        em_dest     <= de_dest;
        em_reg_we   <= de_reg_we;
        em_mem_we   <= de_mem_we;
        em_mem_read <= de_mem_read;
        em_result   <= alu_result;
        em_wdata    <= ex_op2;
    end

    // memory
    assign dmem_we    = em_valid && em_mem_we;
    assign dmem_addr  = em_result;
    assign dmem_wdata = em_wdata;
    assign mem_result = em_mem_read ? dmem_rdata : em_result;

    always_ff @(posedge clk) begin
        mw_pc     <= em_pc;
        mw_dest   <= em_dest;
        mw_reg_we <= em_reg_we;
        mw_data   <= mem_result;
    end

    // writeback trace
    assign wb_valid = mw_valid && mw_reg_we;
    assign wb_pc    = mw_pc;
    assign wb_reg   = mw_dest;
    assign wb_data  = mw_data;

endmodule

//--- hw/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::word_t     inst,
    input  cpu_pkg::word_t     pc,
    output cpu_pkg::alu_op_e   alu_op,
    output cpu_pkg::br_kind_e  br_kind,
    output logic               src1_is_pc,
    output logic               src2_is_imm,
    output logic               rs2_is_rd,
    output logic               reg_we,
    output logic               mem_we,
    output logic               mem_read,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output cpu_pkg::reg_addr_t dest,
    output cpu_pkg::word_t     imm,
    output cpu_pkg::word_t     br_target
);
    import cpu_pkg::*;

    logic  writes;
    logic  is_bl;
    logic  long_offs;
    word_t ui5;
    word_t si12;
    word_t ui12;
    word_t si20;
    word_t off16;
    word_t off26;

    // immediate forms
    assign ui5   = word_t'(inst[14:10]);
    assign si12  = {{20{inst[21]}}, inst[21:10]};
    assign ui12  = {20'b0, inst[21:10]};
    assign si20  = {inst[24:5], 12'b0};
    assign off16 = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign off26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    always_comb begin
        alu_op      = ALU_ADD;
        br_kind     = BR_NONE;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        rs2_is_rd   = 1'b0;
        writes      = 1'b0;
        mem_we      = 1'b0;
        mem_read    = 1'b0;
        is_bl       = 1'b0;
        long_offs   = 1'b0;
        imm         = '0;
        case (inst[31:26])
            6'h00: begin
                writes = 1'b1;
                if (inst[25:22] == 4'h0 && inst[21:20] == 2'b01) begin
                    case (inst[19:15])
                        5'h00:   alu_op = ALU_ADD;
                        5'h02:   alu_op = ALU_SUB;
                        5'h04:   alu_op = ALU_SLT;
                        5'h05:   alu_op = ALU_SLTU;
                        5'h08:   alu_op = ALU_NOR;
                        5'h09:   alu_op = ALU_AND;
                        5'h0a:   alu_op = ALU_OR;
                        5'h0b:   alu_op = ALU_XOR;
                        5'h0e:   alu_op = ALU_SLL;
                        5'h0f:   alu_op = ALU_SRL;
                        5'h10:   alu_op = ALU_SRA;
                        default: writes = 1'b0;
                    endcase
                end else if (inst[25:22] == 4'h1 && inst[21:20] == 2'b00) begin
                    // shift by ui5
                    src2_is_imm = 1'b1;
                    imm         = ui5;
                    case (inst[19:15])
                        5'h01:   alu_op = ALU_SLL;
                        5'h09:   alu_op = ALU_SRL;
                        5'h11:   alu_op = ALU_SRA;
                        default: writes = 1'b0;
                    endcase
                end else begin
                    src2_is_imm = 1'b1;
                    imm         = si12;
                    case (inst[25:22])
                        4'h8: alu_op = ALU_SLT;
                        4'h9: alu_op = ALU_SLTU;
                        4'ha: alu_op = ALU_ADD;
                        4'hd: begin
                            alu_op = ALU_AND;
                            imm    = ui12;
                        end
                        4'he: begin
                            alu_op = ALU_OR;
                            imm    = ui12;
                        end
                        4'hf: begin
                            alu_op = ALU_XOR;
                            imm    = ui12;
                        end
                        default: writes = 1'b0;
                    endcase
                end
            end
            6'h05, 6'h07: begin
                // lu12i.w and pcaddu12i
                writes      = !inst[25];
                src2_is_imm = 1'b1;
                imm         = si20;
                src1_is_pc  = inst[27];
                alu_op      = inst[27] ? ALU_ADD : ALU_LUI;
            end
            6'h0a: begin
                src2_is_imm = 1'b1;
                imm         = si12;
                if (inst[25:22] == 4'h2) begin
                    writes   = 1'b1;
                    mem_read = 1'b1;
                end else if (inst[25:22] == 4'h6) begin
                    mem_we    = 1'b1;
                    rs2_is_rd = 1'b1;
                end
            end
            6'h14: begin
                br_kind   = BR_ALWAYS;
                long_offs = 1'b1;
            end
            6'h15: begin
                // bl links pc + 4 into r1
                br_kind     = BR_ALWAYS;
                long_offs   = 1'b1;
                is_bl       = 1'b1;
                writes      = 1'b1;
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                imm         = 32'd4;
            end
            6'h16: br_kind = BR_EQ;
            6'h17: br_kind = BR_NE;
            6'h18: br_kind = BR_LT;
            6'h19: br_kind = BR_GE;
            6'h1a: br_kind = BR_LTU;
            6'h1b: br_kind = BR_GEU;
            default: ;
        endcase
        // conditional branches compare rj with rd
        if (inst[31:26] >= 6'h16 && inst[31:26] <= 6'h1b) begin
            rs2_is_rd = 1'b1;
        end
    end

    assign rs1       = inst[9:5];
    assign rs2       = inst[14:10];
    assign dest      = is_bl ? 5'd1 : inst[4:0];
    assign reg_we    = writes && (dest != '0);
    assign br_target = pc + (long_offs ? off26 : off16);

    mem_dir_excl: assert final (!(mem_we && mem_read));

endmodule

//--- hw/forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t ex_rs1,
    input  cpu_pkg::reg_addr_t ex_rs2,
    input  cpu_pkg::reg_addr_t id_rs1,
    input  cpu_pkg::reg_addr_t id_rs2,
    input  cpu_pkg::reg_addr_t mem_dest,
    input  cpu_pkg::reg_addr_t wb_dest,
    input  cpu_pkg::reg_addr_t ex_dest,
    input  logic               mem_we,
    input  logic               wb_we,
    input  logic               ex_is_load,
    input  cpu_pkg::word_t     mem_value,
    input  cpu_pkg::word_t     wb_value,
    input  cpu_pkg::word_t     rf1,
    input  cpu_pkg::word_t     rf2,
    output cpu_pkg::word_t     op1,
    output cpu_pkg::word_t     op2,
    output logic               stall
);
    import cpu_pkg::*;

    // newest producer wins
    function automatic word_t pick(reg_addr_t rs, word_t rf);
        if (rs == '0) begin
            return rf;
        end else if (mem_we && mem_dest == rs) begin
            return mem_value;
        end else if (wb_we && wb_dest == rs) begin
            return wb_value;
        end
        return rf;
    endfunction

    always_comb begin
        op1 = pick(ex_rs1, rf1);
        op2 = pick(ex_rs2, rf2);
    end

    // load data is only ready in the memory stage
    assign stall = ex_is_load && (ex_dest != '0)
                   && (ex_dest == id_rs1 || ex_dest == id_rs2);

    single_bubble: assert property (@(posedge clk) disable iff (reset) stall |=> !stall);

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module regfile (
    input  logic               clk,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2
);
    import cpu_pkg::*;

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero, a same-cycle write is passed through
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we && addr == waddr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

    no_r0_write: assert property (@(posedge clk) we |-> waddr != '0);

endmodule

//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and address width
`define XLEN 32

// register file geometry
`define REG_AW 5
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 32'h1c00_0000

// word address width of the data memory model
`define DMEM_AW 8

`endif

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);
    initial begin
        clk   = 1'b0;
        reset = 1'b1;
    end

    // 8 ns period
    always #4 clk = ~clk;

    initial begin
        repeat (5) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- tests/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int N_INST = 200;
    localparam int DMEM_WORDS = 1 << `DMEM_AW;
    localparam int K_REG = 0;
    localparam int K_SHI = 1;
    localparam int K_IMM = 2;
    localparam int K_LUI = 3;
    localparam int K_PCA = 4;
    localparam int K_LD  = 5;
    localparam int K_ST  = 6;
    localparam int K_BR  = 7;
    localparam int K_B   = 8;
    localparam int K_BL  = 9;

    logic      clk;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_rdata;
    logic      dmem_we;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    word_t     dmem_rdata;
    logic      wb_valid;
    word_t     wb_pc;
    reg_addr_t wb_reg;
    word_t     wb_data;

    word_t imem [256];
    word_t dmem [DMEM_WORDS];
    word_t model_mem [DMEM_WORDS];
    word_t model_reg [32];
    int    kind [N_INST];
    int    op [N_INST];
    int    rd [N_INST];
    int    rj [N_INST];
    int    rk [N_INST];
    word_t imm [N_INST];
    int    errors;
    bit    timed_out;
    word_t ioff;

    tb_clock u_clock (.clk(clk), .reset(reset));

    cpu_top dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

    // memories answer in the same cycle
    assign ioff       = imem_addr - `RESET_PC;
    assign imem_rdata = imem[ioff[9:2]];
    assign dmem_rdata = dmem[dmem_addr[`DMEM_AW+1:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[`DMEM_AW+1:2]] <= dmem_wdata;
        end
    end

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    // minor opcode field per instruction format
    function automatic word_t minor_code(int k, alu_op_e o);
        case (o)
            ALU_ADD:  return (k == K_REG) ? 32'h20 : 32'ha;
            ALU_SUB:  return 32'h22;
            ALU_SLT:  return (k == K_REG) ? 32'h24 : 32'h8;
            ALU_SLTU: return (k == K_REG) ? 32'h25 : 32'h9;
            ALU_NOR:  return 32'h28;
            ALU_AND:  return (k == K_REG) ? 32'h29 : 32'hd;
            ALU_OR:   return (k == K_REG) ? 32'h2a : 32'he;
            ALU_XOR:  return (k == K_REG) ? 32'h2b : 32'hf;
            ALU_SLL:  return (k == K_REG) ? 32'h2e : 32'h01;
            ALU_SRL:  return (k == K_REG) ? 32'h2f : 32'h09;
            ALU_SRA:  return (k == K_REG) ? 32'h30 : 32'h11;
            default:  return 32'h0;
        endcase
    endfunction

    function automatic word_t encode(int p);
        word_t w;
        word_t m;
        w = word_t'(rd[p]) | (word_t'(rj[p]) << 5);
        m = minor_code(kind[p], alu_op_e'(op[p]));
        case (kind[p])
            K_REG: w |= (m << 15) | (word_t'(rk[p]) << 10);
            K_SHI: w |= (32'h1 << 22) | (m << 15) | ((imm[p] & 32'h1f) << 10);
            K_IMM: w |= (m << 22) | ((imm[p] & 32'hfff) << 10);
            K_LUI: w = (32'h0a << 25) | ((imm[p] & 32'hfffff) << 5) | word_t'(rd[p]);
            K_PCA: w = (32'h0e << 25) | ((imm[p] & 32'hfffff) << 5) | word_t'(rd[p]);
            K_LD:  w |= (32'h0a2 << 22) | ((imm[p] & 32'hfff) << 10);
            K_ST:  w |= (32'h0a6 << 22) | ((imm[p] & 32'hfff) << 10);
            K_BR:  w |= ((32'h15 + word_t'(op[p])) << 26) | ((imm[p] & 32'hffff) << 10);
            default: begin
                // b and bl split the offset over two fields
                w = ((kind[p] == K_BL) ? 32'h15 : 32'h14) << 26;
                w |= ((imm[p] & 32'hffff) << 10) | ((imm[p] >> 16) & 32'h3ff);
            end
        endcase
        return w;
    endfunction

    function automatic word_t calc(alu_op_e o, word_t a, word_t b);
        case (o)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_AND:  return a & b;
            ALU_NOR:  return ~(a | b);
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            default:  return '0;
        endcase
    endfunction

    function automatic bit branch_taken(int k, word_t a, word_t b);
        case (br_kind_e'(k))
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return $signed(a) < $signed(b);
            BR_GE:   return $signed(a) >= $signed(b);
            BR_LTU:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic gen_program();
        int load_dest;
        int r;
        load_dest = -1;
        for (int p = 0; p < N_INST; p++) begin
            rd[p]  = $urandom % 8;
            rj[p]  = $urandom % 8;
            rk[p]  = $urandom % 8;
            imm[p] = '0;
            op[p]  = int'(ALU_ADD);
            r      = $urandom % 10;
            if (p < 7) begin
                // give r1..r7 known values
                kind[p] = K_IMM;
                rd[p]   = p + 1;
                rj[p]   = 0;
                imm[p]  = $urandom & 32'hfff;
            end else if (p == N_INST - 1) begin
                kind[p] = K_B;
            end else if (load_dest >= 0 || r < 3) begin
                kind[p] = K_REG;
                op[p]   = $urandom % 11;
                if (load_dest >= 0) begin
                    rj[p] = load_dest;
                end
                load_dest = -1;
            end else if (r == 3) begin
                kind[p] = K_SHI;
                op[p]   = int'(ALU_SLL) + $urandom % 3;
                imm[p]  = $urandom & 32'h1f;
            end else if (r == 4) begin
                kind[p] = K_IMM;
                case ($urandom % 6)
                    0: op[p] = int'(ALU_SLT);
                    1: op[p] = int'(ALU_SLTU);
                    2: op[p] = int'(ALU_ADD);
                    3: op[p] = int'(ALU_AND);
                    4: op[p] = int'(ALU_OR);
                    default: op[p] = int'(ALU_XOR);
                endcase
                imm[p] = $urandom & 32'hfff;
            end else if (r == 5) begin
                kind[p] = ($urandom % 2) ? K_LUI : K_PCA;
                imm[p]  = $urandom & 32'hfffff;
            end else if (r < 8) begin
                kind[p] = (r == 6) ? K_LD : K_ST;
                rj[p]   = 0;
                imm[p]  = ($urandom % 256) * 4;
                if (r == 6) begin
                    load_dest = rd[p];
                end
            end else begin
                r = $urandom % 8;
                kind[p] = (r < 6) ? K_BR : ((r == 6) ? K_B : K_BL);
                op[p]   = int'(BR_EQ) + r;
                imm[p]  = 1 + $urandom % 4;
                if (p + int'(imm[p]) > N_INST - 1) begin
                    imm[p] = N_INST - 1 - p;
                end
            end
            imem[p] = encode(p);
        end
    endtask

    task automatic expect_retire(word_t pc, int dst, word_t data);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (wb_valid !== 1'b1 && cycles < 50);
        if (wb_valid !== 1'b1) begin
            $display("no retirement within 50 cycles, expected pc %h", pc);
            errors++;
            timed_out = 1'b1;
        end else begin
            check("wb_pc", pc, wb_pc);
            check("wb_reg", word_t'(dst), word_t'(wb_reg));
            check("wb_data", data, wb_data);
        end
    endtask

    initial begin
        int    p;
        int    next;
        int    dst;
        int    waited;
        bit    writes;
        word_t pcw;
        word_t a;
        word_t b;
        word_t res;
        void'($urandom(56));
        errors    = 0;
        timed_out = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        gen_program();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]      = (32'h9e37_79b9 * (i + 1)) ^ i;
            model_mem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            model_reg[i] = '0;
        end

        #1;
        waited = 0;
        while (reset && waited < 20) begin
            @(negedge clk);
            check("wb_valid", '0, word_t'(wb_valid));
            check("dmem_we", '0, word_t'(dmem_we));
            waited++;
        end
        if (reset) begin
            $display("reset did not end within 20 cycles");
            errors++;
            timed_out = 1'b1;
        end
        check("imem_addr", `RESET_PC, imem_addr);

        p = 0;
        while (p != N_INST - 1 && !timed_out) begin
            pcw    = `RESET_PC + 4 * p;
            writes = 1'b1;
            dst    = rd[p];
            next   = p + 1;
            a      = model_reg[rj[p]];
            b      = model_reg[rk[p]];
            res    = '0;
            case (kind[p])
                K_REG: res = calc(alu_op_e'(op[p]), a, b);
                K_SHI: res = calc(alu_op_e'(op[p]), a, imm[p]);
                K_IMM: begin
                    // logic ops zero-extend ui12
                    if (op[p] inside {int'(ALU_AND), int'(ALU_OR), int'(ALU_XOR)}) begin
                        b = {20'b0, imm[p][11:0]};
                    end else begin
                        b = {{20{imm[p][11]}}, imm[p][11:0]};
                    end
                    res = calc(alu_op_e'(op[p]), a, b);
                end
                K_LUI: res = {imm[p][19:0], 12'b0};
                K_PCA: res = pcw + {imm[p][19:0], 12'b0};
                K_LD:  res = model_mem[imm[p][`DMEM_AW+1:2]];
                K_ST: begin
                    model_mem[imm[p][`DMEM_AW+1:2]] = model_reg[rd[p]];
                    writes = 1'b0;
                end
                K_BR: begin
                    writes = 1'b0;
                    if (branch_taken(op[p], a, model_reg[rd[p]])) begin
                        next = p + int'(imm[p]);
                    end
                end
                K_B: begin
                    writes = 1'b0;
                    next   = p + int'(imm[p]);
                end
                default: begin
                    dst  = 1;
                    res  = pcw + 4;
                    next = p + int'(imm[p]);
                end
            endcase
            if (writes && dst != 0) begin
                model_reg[dst] = res;
                expect_retire(pcw, dst, res);
            end
            p = next;
        end

        // the final loop retires nothing, stores drain meanwhile
        if (!timed_out) begin
            repeat (20) begin
                @(negedge clk);
                check("wb_valid", '0, word_t'(wb_valid));
            end
            for (int i = 0; i < DMEM_WORDS; i++) begin
                check($sformatf("dmem[%0d]", i), model_mem[i], dmem[i]);
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
hw/cpu_pkg.sv
hw/decoder.sv
hw/regfile.sv
hw/alu.sv
hw/forward_unit.sv
hw/cpu_top.sv
tests/tb_clock.sv
tests/tb_cpu.sv
